// File: vlog.f
+incdir+bench
logic/fe_const_pkg.sv
logic/fe_types_pkg.sv
logic/pc_target_calc.sv
logic/branch_history_table.sv
logic/pc_issue_regs.sv
logic/fetch_ctrl.sv
logic/frontend_top.sv
bench/frontend_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module frontend_tb \
    --Mdir obj_dir -o frontend_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/frontend_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: bench/frontend_tests.svh
// directed tests for the fetch front end
// every cycle is also checked against the reference model in run_cycle

// reset state, boot cycle, then sequential fetch
task automatic test_reset_sequential();
    logic [31:0] w;
    logic [31:0] prev;
    apply_reset();
    check_value("fetch_pc", fetch_pc, fe_const_pkg::reset_vector);
    check_value("slot.valid", {31'b0, slot.valid}, 32'h0);
    check_value("flush", {31'b0, flush}, 32'h0);
    w = 32'h0;
    // boot keeps the pc, then one word per cycle
    for (int i = 0; i < 6; i++) begin
        prev = w;
        w = other_word();
        run_cycle(w, 32'h0, 1'b0, '0);
    end
    check_value("fetch_pc", fetch_pc, fe_const_pkg::reset_vector + 32'd20);
    check_value("slot.pc", slot.pc, fe_const_pkg::reset_vector + 32'd16);
    check_value("slot.instr", slot.instr, prev);
endtask

// jal always taken, branch on an untrained counter falls through
task automatic test_jump_branch();
    logic [31:0] joff;
    logic [31:0] boff;
    logic [31:0] jpc;
    logic [31:0] bpc;
    joff = rand_j_off();
    boff = rand_b_off();
    run_cycle(jal_word(joff), joff, 1'b0, '0);
    jpc = m_pc;
    run_cycle(branch_word(boff), boff, 1'b0, '0);
    bpc = m_pc;
    check_value("fetch_pc", fetch_pc, jpc + joff);
    check_value("slot.pred_taken", {31'b0, slot.pred_taken}, 32'h1);
    run_cycle(other_word(), 32'h0, 1'b0, '0);
    check_value("fetch_pc", fetch_pc, bpc + 32'd4);
    check_value("slot.pred_taken", {31'b0, slot.pred_taken}, 32'h0);
    run_cycle(other_word(), 32'h0, 1'b0, '0);
    run_cycle(other_word(), 32'h0, 1'b0, '0);
endtask

// two taken commits ahead of the fetch make the branch predicted taken
task automatic test_branch_training();
    logic [31:0] bpc;
    logic [31:0] boff;
    fe_types_pkg::commit_info_t c;
    // branch sits four words past the current fetch pc
    bpc = m_pc + 32'd16;
    boff = rand_b_off();
    c = make_commit(1'b1, bpc, boff, 1'b1, 1'b1);
    run_cycle(other_word(), 32'h0, 1'b0, c);
    run_cycle(other_word(), 32'h0, 1'b0, c);
    run_cycle(other_word(), 32'h0, 1'b0, '0);
    run_cycle(branch_word(boff), boff, 1'b0, '0);
    check_value("fetch_pc", fetch_pc, bpc);
    run_cycle(other_word(), 32'h0, 1'b0, '0);
    check_value("fetch_pc", fetch_pc, bpc + boff);
    check_value("slot.pred_taken", {31'b0, slot.pred_taken}, 32'h1);
    run_cycle(other_word(), 32'h0, 1'b0, '0);
endtask

// queue full holds pc and slot, one bubble through st_hold on release
task automatic test_back_pressure();
    logic [31:0] w;
    logic [31:0] held_pc;
    w = other_word();
    run_cycle(w, 32'h0, 1'b1, '0);
    held_pc = m_pc;
    run_cycle(w, 32'h0, 1'b1, '0);
    check_value("fetch_pc", fetch_pc, held_pc);
    check_value("slot.valid", {31'b0, slot.valid}, 32'h0);
    run_cycle(w, 32'h0, 1'b1, '0);
    run_cycle(w, 32'h0, 1'b0, '0);
    check_value("fetch_pc", fetch_pc, held_pc);
    run_cycle(w, 32'h0, 1'b0, '0);
    run_cycle(other_word(), 32'h0, 1'b0, '0);
    check_value("fetch_pc", fetch_pc, held_pc + 32'd4);
    check_value("slot.pc", slot.pc, held_pc);
    check_value("slot.instr", slot.instr, w);
endtask

// recovery from both directions, under back-pressure, and non-events
task automatic test_mispredict();
    logic [31:0] cpc;
    logic [31:0] imm;
    logic [31:0] w;
    logic [31:0] p0;
    // wrongly taken, restart after the branch
    cpc = rand_pc();
    run_cycle(other_word(), 32'h0, 1'b0, make_commit(1'b1, cpc, rand_b_off(), 1'b1, 1'b0));
    run_cycle(other_word(), 32'h0, 1'b0, '0);
    check_value("fetch_pc", fetch_pc, cpc + 32'd4);
    check_value("flush", {31'b0, flush}, 32'h1);
    check_value("slot.valid", {31'b0, slot.valid}, 32'h0);
    run_cycle(other_word(), 32'h0, 1'b0, '0);
    check_value("flush", {31'b0, flush}, 32'h0);
    // wrongly not taken, restart at the target
    cpc = rand_pc();
    imm = rand_b_off();
    run_cycle(other_word(), 32'h0, 1'b0, make_commit(1'b1, cpc, imm, 1'b0, 1'b1));
    run_cycle(other_word(), 32'h0, 1'b0, '0);
    check_value("fetch_pc", fetch_pc, cpc + imm);
    check_value("flush", {31'b0, flush}, 32'h1);
    run_cycle(other_word(), 32'h0, 1'b0, '0);
    // mispredict overrides a full queue
    cpc = rand_pc();
    w = other_word();
    run_cycle(w, 32'h0, 1'b1, '0);
    run_cycle(w, 32'h0, 1'b1, make_commit(1'b1, cpc, rand_b_off(), 1'b1, 1'b0));
    w = other_word();
    run_cycle(w, 32'h0, 1'b1, '0);
    check_value("fetch_pc", fetch_pc, cpc + 32'd4);
    check_value("flush", {31'b0, flush}, 32'h1);
    run_cycle(w, 32'h0, 1'b0, '0);
    check_value("flush", {31'b0, flush}, 32'h0);
    check_value("fetch_pc", fetch_pc, cpc + 32'd4);
    run_cycle(w, 32'h0, 1'b0, '0);
    run_cycle(other_word(), 32'h0, 1'b0, '0);
    // matching direction and a non-branch commit change nothing
    p0 = m_pc;
    run_cycle(other_word(), 32'h0, 1'b0, make_commit(1'b1, rand_pc(), 32'h8, 1'b1, 1'b1));
    run_cycle(other_word(), 32'h0, 1'b0, make_commit(1'b0, rand_pc(), 32'h8, 1'b1, 1'b0));
    check_value("flush", {31'b0, flush}, 32'h0);
    run_cycle(other_word(), 32'h0, 1'b0, '0);
    check_value("flush", {31'b0, flush}, 32'h0);
    check_value("fetch_pc", fetch_pc, p0 + 32'd12);
endtask

// File: bench/frontend_tb.sv
// testbench for the instruction fetch front end
// reference model of fetch pc, issue slot, control state and branch counters
`timescale 1ns/100ps

module frontend_tb;

    localparam int clk_period = 100;
    localparam int reset_cycles = 4;
    // reset and boot cycle, then the directed tests in run order
    localparam int test_cycles = reset_cycles + 1 + 6 + 5 + 6 + 6 + 15;
    // op-imm opcode for plain sequential instructions
    localparam logic [6:0] op_imm = 7'b0010011;

    logic                       clk;
    logic                       rst_n;
    logic [31:0]                fetch_instr;
    logic                       queue_full;
    fe_types_pkg::commit_info_t commit;
    logic [31:0]                fetch_pc;
    fe_types_pkg::issue_slot_t  slot;
    logic                       flush;

    integer seed;

    // model state
    logic [31:0]                m_pc;
    fe_const_pkg::ctrl_state_e  m_state;
    fe_types_pkg::issue_slot_t  m_slot;
    logic                       m_slot_loaded;
    logic [1:0]                 m_cnt [64];
    // inputs applied during the current cycle
    logic [31:0]                cur_instr;
    logic [31:0]                cur_off;
    logic                       cur_qf;
    fe_types_pkg::commit_info_t cur_commit;

    frontend_top u_frontend_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_instr (fetch_instr),
        .queue_full  (queue_full),
        .commit      (commit),
        .fetch_pc    (fetch_pc),
        .slot        (slot),
        .flush       (flush)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // watchdog
    initial begin
        #((test_cycles + 50) * clk_period);
        $display("timeout: tests did not finish within %0d cycles", test_cycles + 50);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    task automatic reset_model();
        m_pc = fe_const_pkg::reset_vector;
        m_state = fe_const_pkg::st_boot;
        m_slot = '0;
        m_slot_loaded = 1'b0;
        for (int i = 0; i < 64; i++) begin
            m_cnt[i] = fe_const_pkg::counter_init;
        end
    endtask

    // one clock edge of the front end, from the inputs of the ending cycle
    task automatic advance_model();
        logic        mispred;
        logic        fetch_ok;
        logic        is_br;
        logic        is_jal;
        logic        pred;
        logic [31:0] next_pc;
        logic [1:0]  cnt;
        mispred = cur_commit.valid && cur_commit.is_branch &&
                  (cur_commit.pred_taken != cur_commit.actual_taken);
        fetch_ok = (m_state == fe_const_pkg::st_run ||
                    m_state == fe_const_pkg::st_redirect) && !cur_qf;
        is_br = (cur_instr[6:0] == fe_const_pkg::op_branch);
        is_jal = (cur_instr[6:0] == fe_const_pkg::op_jal);
        // prediction uses the counter before this cycle's training
        pred = (is_br && m_cnt[m_pc[7:2]][1]) || is_jal;
        if (mispred && cur_commit.actual_taken)
            next_pc = cur_commit.pc + cur_commit.imm_se;
        else if (mispred)
            next_pc = cur_commit.pc + fe_const_pkg::pc_step;
        else if (pred)
            next_pc = m_pc + cur_off;
        else
            next_pc = m_pc + fe_const_pkg::pc_step;
        // wrong path fetch is not handed to the queue
        m_slot.valid = fetch_ok && !mispred;
        if (m_slot.valid) begin
            m_slot.pc = m_pc;
            m_slot.instr = cur_instr;
            m_slot.pred_taken = pred;
            m_slot_loaded = 1'b1;
        end
        // saturating counter training
        if (cur_commit.valid && cur_commit.is_branch) begin
            cnt = m_cnt[cur_commit.pc[7:2]];
            if (cur_commit.actual_taken && cnt != 2'b11)
                cnt = cnt + 2'd1;
            else if (!cur_commit.actual_taken && cnt != 2'b00)
                cnt = cnt - 2'd1;
            m_cnt[cur_commit.pc[7:2]] = cnt;
        end
        if (mispred || fetch_ok)
            m_pc = next_pc;
        if (mispred)
            m_state = fe_const_pkg::st_redirect;
        else if (cur_qf)
            m_state = fe_const_pkg::st_hold;
        else
            m_state = fe_const_pkg::st_run;
    endtask

    task automatic check_outputs();
        logic exp_flush;
        exp_flush = (m_state == fe_const_pkg::st_redirect);
        check_value("fetch_pc", fetch_pc, m_pc);
        check_value("flush", {31'b0, flush}, {31'b0, exp_flush});
        check_value("slot.valid", {31'b0, slot.valid}, {31'b0, m_slot.valid});
        // payload is only defined once something was loaded
        if (m_slot_loaded) begin
            check_value("slot.pc", slot.pc, m_slot.pc);
            check_value("slot.instr", slot.instr, m_slot.instr);
            check_value("slot.pred_taken", {31'b0, slot.pred_taken},
                        {31'b0, m_slot.pred_taken});
        end
    endtask

    // drive one cycle on the rising edge, check at the falling edge
    task automatic run_cycle(input logic [31:0] instr, input logic [31:0] off,
                             input logic qf, input fe_types_pkg::commit_info_t c);
        @(posedge clk);
        advance_model();
        cur_instr = instr;
        cur_off = off;
        cur_qf = qf;
        cur_commit = c;
        fetch_instr <= instr;
        queue_full <= qf;
        commit <= c;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic apply_reset();
        logic [31:0] w;
        w = other_word();
        rst_n <= 1'b0;
        queue_full <= 1'b0;
        commit <= '0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        fetch_instr <= w;
        reset_model();
        cur_instr = w;
        cur_off = 32'h0;
        cur_qf = 1'b0;
        cur_commit = '0;
        @(negedge clk);
        check_outputs();
    endtask

    function automatic logic [31:0] other_word();
        logic [31:0] r;
        r = $random(seed);
        return {r[31:7], op_imm};
    endfunction

    function automatic logic [31:0] jal_word(input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, fe_const_pkg::op_jal};
    endfunction

    // beq x1, x2
    function automatic logic [31:0] branch_word(input logic [31:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11],
                fe_const_pkg::op_branch};
    endfunction

    function automatic logic [31:0] rand_b_off();
        logic [31:0] r;
        r = $random(seed);
        return {{19{r[12]}}, r[12:1], 1'b0};
    endfunction

    function automatic logic [31:0] rand_j_off();
        logic [31:0] r;
        r = $random(seed);
        return {{11{r[20]}}, r[20:1], 1'b0};
    endfunction

    function automatic logic [31:0] rand_pc();
        logic [31:0] r;
        r = $random(seed);
        return {r[31:2], 2'b00};
    endfunction

    function automatic fe_types_pkg::commit_info_t make_commit(input logic is_br,
        input logic [31:0] pc, input logic [31:0] imm, input logic pred, input logic actual);
        fe_types_pkg::commit_info_t c;
        c.valid = 1'b1;
        c.is_branch = is_br;
        c.pc = pc;
        c.imm_se = imm;
        c.pred_taken = pred;
        c.actual_taken = actual;
        return c;
    endfunction

    `include "frontend_tests.svh"

    initial begin
        seed = 32'ha8bd;
        rst_n = 1'b0;
        fetch_instr = 32'h0;
        queue_full = 1'b0;
        commit = '0;
        test_reset_sequential();
        test_jump_branch();
        test_branch_training();
        test_back_pressure();
        test_mispredict();
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: logic/frontend_top.sv
// instruction fetch front end
// next-pc calculation, branch history table, pc and issue slot registers
// and the fetch control FSM
`timescale 1ns/100ps

module frontend_top (
    input  logic                      clk,
    input  logic                      rst_n,
    // instruction at fetch_pc, same cycle
    input  logic [31:0]               fetch_instr,
    input  logic                      queue_full,
    input  fe_types_pkg::commit_info_t commit,
    output logic [31:0]               fetch_pc,
    output fe_types_pkg::issue_slot_t slot,
    output logic                      flush
);

    fe_types_pkg::redirect_t redir;
    logic bht_taken;
    logic pc_en;
    logic slot_load;

    // combinational next pc and mispredict detect
    pc_target_calc u_pc_target_calc (
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .commit      (commit),
        .bht_taken   (bht_taken),
        .redir       (redir)
    );

    // direction prediction for the fetch pc
    branch_history_table u_branch_history_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_pc  (fetch_pc),
        .commit    (commit),
        .bht_taken (bht_taken)
    );

    // pc and slot state
    pc_issue_regs u_pc_issue_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .redir       (redir),
        .fetch_instr (fetch_instr),
        .pc_en       (pc_en),
        .slot_load   (slot_load),
        .fetch_pc    (fetch_pc),
        .slot        (slot)
    );

    // stall, recovery and flush
    fetch_ctrl u_fetch_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .queue_full   (queue_full),
        .mispredicted (redir.mispredicted),
        .pc_en        (pc_en),
        .slot_load    (slot_load),
        .flush        (flush)
    );

endmodule

// File: logic/fetch_ctrl.sv
// fetch control FSM
// grants pc and slot updates under back-pressure, lets a committed
// mispredict override the stall and raises a one cycle flush afterwards
`timescale 1ns/100ps

module fetch_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic queue_full,
    input  logic mispredicted,
    output logic pc_en,
    output logic slot_load,
    output logic flush
);

    fe_const_pkg::ctrl_state_e state;
    fe_const_pkg::ctrl_state_e state_nxt;
    logic fetch_ok;

    // normal fetch only from run or redirect with room in the queue
    assign fetch_ok = ((state == fe_const_pkg::st_run) ||
                       (state == fe_const_pkg::st_redirect)) && !queue_full;

    // recovery moves the pc even when the queue is full
    assign pc_en = mispredicted | fetch_ok;

    // fetched instruction is wrong path on a mispredict
    assign slot_load = fetch_ok & ~mispredicted;

    // flush for ROB and issue queue, one cycle after the mispredict
    assign flush = (state == fe_const_pkg::st_redirect);

    // boot lasts a single cycle with pc held at the reset vector
    // mispredict first, then back-pressure
    always_comb begin
        if (mispredicted) begin
            state_nxt = fe_const_pkg::st_redirect;
        end else if (queue_full) begin
            state_nxt = fe_const_pkg::st_hold;
        end else begin
            state_nxt = fe_const_pkg::st_run;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= fe_const_pkg::st_boot;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// File: logic/pc_issue_regs.sv
// fetch pc register and issue slot register
// pc follows the next-pc result when enabled, slot captures the current fetch
`timescale 1ns/100ps

module pc_issue_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  fe_types_pkg::redirect_t  redir,
    input  logic [31:0]              fetch_instr,
    input  logic                     pc_en,
    input  logic                     slot_load,
    output logic [31:0]              fetch_pc,
    output fe_types_pkg::issue_slot_t slot
);

    // fetch pc
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_pc <= fe_const_pkg::reset_vector;
        end else if (pc_en) begin
            // sequential, predicted target or recovery pc
            fetch_pc <= redir.pc_update;
        end
    end

    // issue slot
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot.valid <= 1'b0;
        end else begin
            // one cycle per load, drops while held
            slot.valid <= slot_load;
        end

        // payload keeps its value while the queue is full
        if (slot_load) begin
            slot.pc         <= fetch_pc;
            slot.instr      <= fetch_instr;
            slot.pred_taken <= redir.pred_taken;
        end
    end

endmodule

// File: logic/branch_history_table.sv
// branch history table
// 2-bit saturating counters, read by fetch pc, trained by committed branches
`timescale 1ns/100ps

module branch_history_table (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [31:0]               fetch_pc,
    input  fe_types_pkg::commit_info_t commit,
    output logic                      bht_taken
);

    localparam int idx_msb = fe_const_pkg::bht_index_bits + 1;

    logic [1:0] counters [fe_const_pkg::bht_entries];
    logic [fe_const_pkg::bht_index_bits-1:0] rd_idx;
    logic [fe_const_pkg::bht_index_bits-1:0] wr_idx;
    logic [1:0] cur_cnt;
    logic [1:0] new_cnt;
    logic       train;

    // word aligned pc, drop the low two bits
    assign rd_idx = fetch_pc[idx_msb:2];
    assign wr_idx = commit.pc[idx_msb:2];

    // upper bit set means taken
    assign bht_taken = counters[rd_idx][1];

    // only valid branch commits train
    assign train   = commit.valid & commit.is_branch;
    assign cur_cnt = counters[wr_idx];

    // saturate toward the resolved direction
    always_comb begin
        new_cnt = cur_cnt;
        if (commit.actual_taken) begin
            if (cur_cnt != 2'b11) begin
                new_cnt = cur_cnt + 2'd1;
            end
        end else begin
            if (cur_cnt != 2'b00) begin
                new_cnt = cur_cnt - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // whole table back to weakly not taken
            for (int i = 0; i < fe_const_pkg::bht_entries; i++) begin
                counters[i] <= fe_const_pkg::counter_init;
            end
        end else if (train) begin
            counters[wr_idx] <= new_cnt;
        end
    end

endmodule

// File: logic/pc_target_calc.sv
// next fetch pc calculation
// decodes branch and jal, extracts offsets, detects a committed mispredict
// and adds the selected base and addend
`timescale 1ns/100ps

module pc_target_calc (
    input  logic [31:0]               fetch_pc,
    input  logic [31:0]               fetch_instr,
    input  fe_types_pkg::commit_info_t commit,
    input  logic                      bht_taken,
    output fe_types_pkg::redirect_t   redir
);

    fe_const_pkg::opcode_e op;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        is_branch;
    logic        is_jal;
    logic        mispredicted;
    logic        wrongly_taken;
    logic [31:0] base;
    logic [31:0] addend;

    // opcode decode, anything else is plain sequential
    always_comb begin
        case (fetch_instr[6:0])
            fe_const_pkg::op_branch: op = fe_const_pkg::op_branch;
            fe_const_pkg::op_jal:    op = fe_const_pkg::op_jal;
            default:                 op = fe_const_pkg::op_other;
        endcase
    end

    assign is_branch = (op == fe_const_pkg::op_branch);
    assign is_jal    = (op == fe_const_pkg::op_jal);

    // B-type offset
    assign imm_b = {{19{fetch_instr[31]}}, fetch_instr[31], fetch_instr[7],
                    fetch_instr[30:25], fetch_instr[11:8], 1'b0};
    // J-type offset
    assign imm_j = {{11{fetch_instr[31]}}, fetch_instr[31], fetch_instr[19:12],
                    fetch_instr[20], fetch_instr[30:21], 1'b0};

    // committed branch whose guess was wrong
    assign mispredicted  = commit.valid & commit.is_branch &
                           (commit.pred_taken ^ commit.actual_taken);
    assign wrongly_taken = commit.pred_taken & ~commit.actual_taken;

    always_comb begin
        if (mispredicted) begin
            // recovery restarts from the committed branch
            base = commit.pc;
            if (wrongly_taken) begin
                // fall through after the branch
                addend = fe_const_pkg::pc_step;
            end else begin
                // branch should have gone to its target
                addend = commit.imm_se;
            end
        end else if (is_branch && bht_taken) begin
            base   = fetch_pc;
            addend = imm_b;
        end else if (is_jal) begin
            // jal always taken
            base   = fetch_pc;
            addend = imm_j;
        end else begin
            base   = fetch_pc;
            addend = fe_const_pkg::pc_step;
        end
    end

    assign redir.mispredicted = mispredicted;
    assign redir.pc_update    = base + addend;
    // prediction of the instruction at fetch_pc, recovery not included
    assign redir.pred_taken   = (is_branch & bht_taken) | is_jal;

endmodule

// File: logic/fe_types_pkg.sv
// fetch front end bundles
// commit report from the ROB, issue slot toward the queue, next-pc result
package fe_types_pkg;

    // one retiring instruction as reported by the commit port
    typedef struct packed {
        // single cycle valid
        logic        valid;
        logic        is_branch;
        // pc of the committed instruction
        logic [31:0] pc;
        // branch offset, already sign extended
        logic [31:0] imm_se;
        // direction fetch guessed
        logic        pred_taken;
        // direction the branch resolved to
        logic        actual_taken;
    } commit_info_t;

    // registered fetch result handed to the issue queue
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        // fetch followed a taken branch or jump here
        logic        pred_taken;
    } issue_slot_t;

    // output of the next-pc calculation
    typedef struct packed {
        // commit port shows a wrong direction
        logic        mispredicted;
        // next fetch pc when the pc register is enabled
        logic [31:0] pc_update;
        // current fetch changes flow
        logic        pred_taken;
    } redirect_t;

endpackage

// File: logic/fe_const_pkg.sv
// fetch front end constants
// reset vector, pc step, branch table sizing, opcode and control state encodings
package fe_const_pkg;

    // fetch pc after reset
    localparam logic [31:0] reset_vector = 32'h0000_0000;

    // sequential fetch step, no compressed instructions
    localparam logic [31:0] pc_step = 32'd4;

    // branch table indexed by pc[7:2]
    localparam int bht_index_bits = 6;
    localparam int bht_entries = 1 << bht_index_bits;

    // weakly not taken
    localparam logic [1:0] counter_init = 2'b01;

    // only the opcodes the front end cares about
    typedef enum logic [6:0] {
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_other  = 7'b0000000
    } opcode_e;

    // fetch control states
    typedef enum logic [1:0] {
        st_boot,
        st_run,
        st_hold,
        st_redirect
    } ctrl_state_e;

endpackage
